// ==== filelist.f ====
+incdir+source
source/tsn_map_pkg.sv
source/tsn_map_ifs.sv
source/frame_parser.sv
source/flow_table.sv
source/frame_fifo.sv
source/mapped_frame_outport.sv
source/tsn_map_top.sv
test/tb_tsn_map.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it. A $fatal in the run gives a non-zero exit.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_tsn_map \
    -Mdir obj_dir -o tb_tsn_map &&
./obj_dir/tb_tsn_map || exit 1

// ==== test/tb_tsn_map.sv ====
// self-checking testbench for the TSN mapping stage, run through filelist.f with tb_tsn_map as top
`include "tsn_map_defs.svh"
`default_nettype none

module tb_tsn_map
    import tsn_map_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_FRAMES      = 200;
    localparam int REPROGRAM_EVERY = 40;
    localparam int ENTRIES         = `TSN_MAP_TABLE_ENTRIES;
    // gapped ingress, drain and lookup latency of the longest frame
    localparam int MAX_FRAME_CYCLES = 4 * `TSN_MAP_FIFO_DEPTH + `TSN_MAP_FIFO_DEPTH + 16;
    localparam int TIMEOUT_NS = NUM_FRAMES * MAX_FRAME_CYCLES * CLK_PERIOD + 10000;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    logic [7:0]     in_data;
    logic           in_last;
    logic           in_ready;
    logic           cfg_wr;
    logic [2:0]     cfg_index;
    logic           cfg_valid;
    logic [47:0]    cfg_key;
    lookup_result_t cfg_result;
    logic           data_wr;
    logic [7:0]     data;
    logic           data_last;
    logic [47:0]    tsntag;
    logic [2:0]     pkt_type;
    logic           hit;
    logic           replication;
    logic           tsn_flag;

    ////////////////////
    // reference model
    ////////////////////

    logic           tbl_valid [ENTRIES];
    logic [47:0]    tbl_key   [ENTRIES];
    lookup_result_t tbl_res   [ENTRIES];

    // one entry per expected output byte, bit 8 is last
    logic [8:0]     exp_bytes [$];
    lookup_result_t exp_res   [$];
    logic           exp_flag  [$];

    integer         seed;
    int             frames_sent;
    int             frames_out;
    logic           in_frame;
    lookup_result_t cur_res;
    logic           cur_flag;

    tsn_map_top uut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_in_valid    (in_valid),
        .i_in_data     (in_data),
        .i_in_last     (in_last),
        .o_in_ready    (in_ready),
        .i_cfg_wr      (cfg_wr),
        .i_cfg_index   (cfg_index),
        .i_cfg_valid   (cfg_valid),
        .i_cfg_key     (cfg_key),
        .i_cfg_result  (cfg_result),
        .o_data_wr     (data_wr),
        .o_data        (data),
        .o_data_last   (data_last),
        .o_tsntag      (tsntag),
        .o_pkt_type    (pkt_type),
        .o_hit         (hit),
        .o_replication (replication),
        .o_tsn_flag    (tsn_flag)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        fail_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_result(input lookup_result_t got, input logic [2:0] got_type,
                                input lookup_result_t exp);
        if (got.hit !== exp.hit) begin
            report_mismatch("o_hit", got.hit, exp.hit);
        end else if (got.replication !== exp.replication) begin
            report_mismatch("o_replication", got.replication, exp.replication);
        end else if (got.tsntag !== exp.tsntag) begin
            report_mismatch("o_tsntag", got.tsntag, exp.tsntag);
        end else if (got_type !== exp.tsntag[47:45]) begin
            // packet type is the top three tag bits
            report_mismatch("o_pkt_type", got_type, exp.tsntag[47:45]);
        end
    endtask

    task automatic check_byte(input logic [8:0] got, input logic [8:0] exp);
        if (got[8] !== exp[8]) begin
            report_mismatch("o_data_last", got[8], exp[8]);
        end else if (got[7:0] !== exp[7:0]) begin
            report_mismatch("o_data", got[7:0], exp[7:0]);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [47:0] rand48();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi[15:0], lo};
    endfunction

    // lowest valid entry with a matching key, all zeros otherwise
    function automatic lookup_result_t predict(input logic [47:0] key);
        for (int i = 0; i < ENTRIES; i++) begin
            if (tbl_valid[i] && tbl_key[i] == key) begin
                return tbl_res[i];
            end
        end
        return '0;
    endfunction

    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    task automatic write_entry(input int idx, input logic valid, input logic [47:0] key,
                               input lookup_result_t res);
        cfg_wr     = 1'b1;
        cfg_index  = idx[2:0];
        cfg_valid  = valid;
        cfg_key    = key;
        cfg_result = res;
        next_drive_point();
        cfg_wr           = 1'b0;
        tbl_valid[idx]   = valid;
        tbl_key[idx]     = key;
        tbl_res[idx]     = res;
    endtask

    task automatic program_random_entry(input int idx);
        lookup_result_t res;
        res.hit         = 1'b1;
        res.replication = (rand_below(2) == 1);
        res.tsntag      = rand48();
        write_entry(idx, rand_below(4) != 0, rand48(), res);
    endtask

    // holds the byte until the parser takes it
    task automatic drive_byte(input logic [7:0] b, input logic last);
        in_valid = 1'b1;
        in_data  = b;
        in_last  = last;
        while (in_ready !== 1'b1) begin
            next_drive_point();
        end
        next_drive_point();
    endtask

    task automatic send_frame();
        int             len;
        logic [47:0]    dst;
        logic [15:0]    etype;
        logic [7:0]     b;
        lookup_result_t res;
        len   = 14 + rand_below(51);
        dst   = (rand_below(4) != 0) ? tbl_key[rand_below(ENTRIES)] : rand48();
        etype = (rand_below(2) == 1) ? `TSN_MAP_TSN_ETHERTYPE : 16'(rand_below(65536));
        res   = predict(dst);
        exp_res.push_back(res);
        // a mapped flow drops the raw TSN marking
        exp_flag.push_back(!res.hit && etype == `TSN_MAP_TSN_ETHERTYPE);
        for (int i = 0; i < len; i++) begin
            if (i < `TSN_MAP_KEY_BYTES) begin
                b = dst[47 - 8 * i -: 8];
            end else if (i == `TSN_MAP_ETYPE_OFFSET) begin
                b = etype[15:8];
            end else if (i == `TSN_MAP_ETYPE_OFFSET + 1) begin
                b = etype[7:0];
            end else begin
                b = 8'(rand_below(256));
            end
            exp_bytes.push_back({i == len - 1, b});
            if (rand_below(4) == 0) begin
                in_valid = 1'b0;
                repeat (1 + rand_below(3)) next_drive_point();
            end
            drive_byte(b, i == len - 1);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        frames_sent++;
    endtask

    ////////////////////
    // egress monitor
    ////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            if (data_wr) begin
                if (exp_bytes.size() == 0) begin
                    fail_run("an output byte appeared with no frame expected");
                end else begin
                    if (!in_frame) begin
                        cur_res  = exp_res.pop_front();
                        cur_flag = exp_flag.pop_front();
                        in_frame = 1'b1;
                    end
                    check_result({hit, replication, tsntag}, pkt_type, cur_res);
                    check_bit("o_tsn_flag", tsn_flag, cur_flag);
                    check_byte({data_last, data}, exp_bytes.pop_front());
                    if (data_last) begin
                        in_frame = 1'b0;
                        frames_out++;
                    end
                end
            end else if (in_frame) begin
                fail_run("the output frame stopped before its last byte");
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("timeout, the frames did not all come out in time");
    end

    initial begin
        int idx;
        seed        = 98136;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = 8'd0;
        in_last     = 1'b0;
        cfg_wr      = 1'b0;
        cfg_index   = 3'd0;
        cfg_valid   = 1'b0;
        cfg_key     = 48'd0;
        cfg_result  = '0;
        frames_sent = 0;
        frames_out  = 0;
        in_frame    = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        check_bit("o_in_ready", in_ready, 1'b0);
        check_bit("o_data_wr", data_wr, 1'b0);
        rst_n = 1'b1;
        next_drive_point();
        next_drive_point();
        check_bit("o_in_ready", in_ready, 1'b1);
        check_bit("o_data_wr", data_wr, 1'b0);

        for (int i = 0; i < ENTRIES; i++) begin
            program_random_entry(i);
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            // table changes only while no frame is in flight
            if (f > 0 && f % REPROGRAM_EVERY == 0) begin
                wait (frames_out == frames_sent);
                next_drive_point();
                program_random_entry(rand_below(ENTRIES));
                idx = rand_below(ENTRIES);
                write_entry(idx, 1'b0, tbl_key[idx], tbl_res[idx]);
            end
            send_frame();
        end

        wait (frames_out == NUM_FRAMES);
        next_drive_point();
        if (exp_bytes.size() == 0 && exp_res.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("expected frames were left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== source/tsn_map_top.sv ====
// top level of the TSN ingress mapping stage, ties parser, buffer, table and outport together
`include "tsn_map_defs.svh"
`default_nettype none

module tsn_map_top
    import tsn_map_pkg::*;
(
    input  wire                                       i_clk,
    input  wire                                       i_rst_n,

    // ingress
    input  wire                                       i_in_valid,
    input  wire  [7:0]                                i_in_data,
    input  wire                                       i_in_last,
    output wire                                       o_in_ready,

    // flow table configuration
    input  wire                                       i_cfg_wr,
    input  wire  [$clog2(`TSN_MAP_TABLE_ENTRIES)-1:0] i_cfg_index,
    input  wire                                       i_cfg_valid,
    input  wire  [47:0]                               i_cfg_key,
    input  wire  lookup_result_t                      i_cfg_result,

    // egress
    output wire                                       o_data_wr,
    output wire  [7:0]                                o_data,
    output wire                                       o_data_last,
    output wire  [47:0]                               o_tsntag,
    output wire  [2:0]                                o_pkt_type,
    output wire                                       o_hit,
    output wire                                       o_replication,
    output wire                                       o_tsn_flag
);

    frame_fifo_if u_fifo_if ();
    lookup_if     u_lkp_if ();

    frame_parser u_parser (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .i_in_last  (i_in_last),
        .o_in_ready (o_in_ready),
        .fifo       (u_fifo_if.writer),
        .lkp        (u_lkp_if.requester)
    );

    flow_table u_table (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_index  (i_cfg_index),
        .i_cfg_valid  (i_cfg_valid),
        .i_cfg_key    (i_cfg_key),
        .i_cfg_result (i_cfg_result),
        .lkp          (u_lkp_if.responder)
    );

    frame_fifo u_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .fifo    (u_fifo_if.buffer)
    );

    mapped_frame_outport u_outport (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .fifo          (u_fifo_if.reader),
        .lkp           (u_lkp_if.receiver),
        .o_data_wr     (o_data_wr),
        .o_data        (o_data),
        .o_data_last   (o_data_last),
        .o_tsntag      (o_tsntag),
        .o_pkt_type    (o_pkt_type),
        .o_hit         (o_hit),
        .o_replication (o_replication),
        .o_tsn_flag    (o_tsn_flag)
    );

endmodule

`default_nettype wire

// ==== source/mapped_frame_outport.sv ====
// egress of the mapping stage, streams the buffered frame with its lookup metadata
`default_nettype none

module mapped_frame_outport
    import tsn_map_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_rst_n,

    frame_fifo_if.reader fifo,
    lookup_if.receiver   lkp,

    output logic         o_data_wr,
    output logic [7:0]   o_data,
    output logic         o_data_last,
    output logic [47:0]  o_tsntag,
    output logic [2:0]   o_pkt_type,
    output logic         o_hit,
    output logic         o_replication,
    output logic         o_tsn_flag
);

    outport_state_e state;
    logic           rd_q;
    lookup_result_t res_q;
    logic           tsn_q;

    // first read goes out with finish so byte 0 is ready in the first cycle
    assign fifo.rd = ((state == OS_IDLE) && lkp.finish) || rd_q;

    ////////////////////
    // read control
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= OS_IDLE;
            rd_q      <= 1'b0;
            o_data_wr <= 1'b0;
        end else begin
            case (state)
                OS_IDLE: begin
                    o_data_wr <= 1'b0;
                    rd_q      <= lkp.finish;
                    if (lkp.finish) begin
                        state <= OS_FIRST;
                    end
                end
                OS_FIRST: begin
                    o_data_wr <= 1'b1;
                    rd_q      <= 1'b1;
                    state     <= OS_NOT_FIRST;
                end
                OS_NOT_FIRST: begin
                    o_data_wr <= 1'b1;
                    // one read past the end lands on an empty buffer
                    if (fifo.rdata[8]) begin
                        rd_q  <= 1'b0;
                        state <= OS_IDLE;
                    end
                end
                default: begin
                    o_data_wr <= 1'b0;
                    rd_q      <= 1'b0;
                    state     <= OS_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // data and metadata
    ////////////////////

    always_ff @(posedge i_clk) begin
        case (state)
            OS_IDLE: begin
                o_data        <= 8'd0;
                o_data_last   <= 1'b0;
                o_tsntag      <= 48'd0;
                o_pkt_type    <= 3'd0;
                o_hit         <= 1'b0;
                o_replication <= 1'b0;
                o_tsn_flag    <= 1'b0;
                if (lkp.finish) begin
                    res_q <= lkp.result;
                    tsn_q <= lkp.tsn_flag;
                end
            end
            OS_FIRST: begin
                o_tsntag      <= res_q.tsntag;
                // packet type sits in the top bits of the tag
                o_pkt_type    <= res_q.tsntag[47:45];
                o_hit         <= res_q.hit;
                o_replication <= res_q.replication;
                // a mapped flow is no longer treated as a raw TSN frame
                o_tsn_flag    <= res_q.hit ? 1'b0 : tsn_q;
                o_data        <= fifo.rdata[7:0];
                o_data_last   <= fifo.rdata[8];
            end
            default: begin
                o_data      <= fifo.rdata[7:0];
                o_data_last <= fifo.rdata[8];
            end
        endcase
    end

    // parser holds one frame at a time, so no result arrives mid-frame
    a_finish_only_in_idle : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        lkp.finish |-> state == OS_IDLE);

endmodule

`default_nettype wire

// ==== source/frame_fifo.sv ====
// byte buffer between parser and outport, holds one frame with its last markers
`include "tsn_map_defs.svh"
`default_nettype none

module frame_fifo (
    input  wire          i_clk,
    input  wire          i_rst_n,

    frame_fifo_if.buffer fifo
);

    localparam int DEPTH = `TSN_MAP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [8:0]     mem [DEPTH];
    // extra top bit tells full from empty
    logic [PTR_W:0] wptr;
    logic [PTR_W:0] rptr;
    logic           full;
    logic           wr_en;
    logic           rd_en;

    assign fifo.empty = (wptr == rptr);
    assign full       = (wptr[PTR_W] != rptr[PTR_W]) &&
                        (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);

    // requests past the limits are dropped
    assign wr_en = fifo.wr && !full;
    assign rd_en = fifo.rd && !fifo.empty;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + 1'b1;
            end
            if (rd_en) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wptr[PTR_W-1:0]] <= fifo.wdata;
        end
        if (rd_en) begin
            fifo.rdata <= mem[rptr[PTR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== source/flow_table.sv ====
// flow table of the mapping stage, written by configuration ports and looked up by key
`include "tsn_map_defs.svh"
`default_nettype none

module flow_table
    import tsn_map_pkg::*;
(
    input  wire                                       i_clk,
    input  wire                                       i_rst_n,

    input  wire                                       i_cfg_wr,
    input  wire [$clog2(`TSN_MAP_TABLE_ENTRIES)-1:0]  i_cfg_index,
    input  wire                                       i_cfg_valid,
    input  wire [47:0]                                i_cfg_key,
    input  wire lookup_result_t                       i_cfg_result,

    lookup_if.responder                               lkp
);

    localparam int ENTRIES = `TSN_MAP_TABLE_ENTRIES;

    logic [ENTRIES-1:0] ent_valid;
    logic [47:0]        ent_key [ENTRIES];
    lookup_result_t     ent_result [ENTRIES];

    logic [ENTRIES-1:0] match_q;
    logic               stage1_q;
    lookup_result_t     sel_result;

    ////////////////////
    // entry storage
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ent_valid <= '0;
        end else if (i_cfg_wr) begin
            ent_valid[i_cfg_index] <= i_cfg_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cfg_wr) begin
            ent_key[i_cfg_index]    <= i_cfg_key;
            ent_result[i_cfg_index] <= i_cfg_result;
        end
    end

    ////////////////////
    // two-stage lookup
    ////////////////////

    // stage one, match vector against the request key
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < ENTRIES; i++) begin
            match_q[i] <= ent_valid[i] && (ent_key[i] == lkp.key);
        end
    end

    // lowest index wins, all zeros on a miss
    always_comb begin
        sel_result = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (match_q[i]) begin
                sel_result = ent_result[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stage1_q   <= 1'b0;
            lkp.finish <= 1'b0;
        end else begin
            stage1_q   <= lkp.req;
            lkp.finish <= stage1_q;
        end
    end

    // stage two, result held until the next lookup
    always_ff @(posedge i_clk) begin
        if (stage1_q) begin
            lkp.result <= sel_result;
        end
    end

    // one pulse per lookup, its finish two cycles later
    a_finish_after_req : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        lkp.req |=> !lkp.req ##1 lkp.finish);

endmodule

`default_nettype wire

// ==== source/frame_parser.sv ====
// ingress side of the mapping stage, buffers each frame and requests its flow-table lookup
`include "tsn_map_defs.svh"
`default_nettype none

module frame_parser
    import tsn_map_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,

    input  wire         i_in_valid,
    input  wire  [7:0]  i_in_data,
    input  wire         i_in_last,
    output logic        o_in_ready,

    frame_fifo_if.writer fifo,
    lookup_if.requester  lkp
);

    // counts up to a full buffer
    localparam int CNT_W = $clog2(`TSN_MAP_FIFO_DEPTH) + 1;

    parser_state_e    state;
    logic [CNT_W-1:0] byte_cnt;
    logic [47:0]      key_q;
    logic [7:0]       etype_hi;
    logic             etype_match;
    logic             accept;

    assign accept      = i_in_valid & o_in_ready;
    assign fifo.wr     = accept;
    assign fifo.wdata  = {i_in_last, i_in_data};
    assign lkp.key     = key_q;

    ////////////////////
    // frame control
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= PS_IDLE;
            o_in_ready <= 1'b0;
            lkp.req    <= 1'b0;
            byte_cnt   <= '0;
        end else begin
            lkp.req <= 1'b0;
            if (accept) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            case (state)
                PS_IDLE: begin
                    o_in_ready <= 1'b1;
                    if (accept) begin
                        state <= PS_HEADER;
                    end
                end
                PS_HEADER: begin
                    // second EtherType byte closes the header
                    if (accept && byte_cnt == `TSN_MAP_ETYPE_OFFSET + 1) begin
                        state <= PS_BODY;
                    end
                end
                PS_BODY: begin
                    state <= PS_BODY;
                end
                PS_LOOKUP: begin
                    if (lkp.finish) begin
                        state <= PS_DRAIN_WAIT;
                    end
                end
                PS_DRAIN_WAIT: begin
                    // outport has pulled every byte out
                    if (fifo.empty) begin
                        state      <= PS_IDLE;
                        o_in_ready <= 1'b1;
                        byte_cnt   <= '0;
                    end
                end
                default: begin
                    state <= PS_IDLE;
                end
            endcase
            // end of frame wins over the per-state updates
            if (accept && i_in_last) begin
                state      <= PS_LOOKUP;
                o_in_ready <= 1'b0;
                lkp.req    <= 1'b1;
            end
        end
    end

    ////////////////////
    // header capture
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (accept) begin
            if (byte_cnt < `TSN_MAP_KEY_BYTES) begin
                key_q <= {key_q[39:0], i_in_data};
            end
            if (byte_cnt == `TSN_MAP_ETYPE_OFFSET) begin
                etype_hi <= i_in_data;
            end
            if (byte_cnt == `TSN_MAP_ETYPE_OFFSET + 1) begin
                etype_match <= ({etype_hi, i_in_data} == `TSN_MAP_TSN_ETHERTYPE);
            end else if (state == PS_IDLE) begin
                etype_match <= 1'b0;
            end
        end
        // flag stays put until the next request
        if (lkp.req) begin
            lkp.tsn_flag <= etype_match;
        end
    end

    // buffer starts empty for each frame, so the frame count bounds its fill
    a_no_write_when_full : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        fifo.wr |-> byte_cnt < `TSN_MAP_FIFO_DEPTH);

endmodule

`default_nettype wire

// ==== source/tsn_map_ifs.sv ====
// internal buses of the mapping stage, frame buffer access and flow-table lookup
`default_nettype none

////////////////////
// frame buffer bus
////////////////////

interface frame_fifo_if;
    // bit 8 is the last marker, bits 7..0 the byte
    logic       wr;
    logic [8:0] wdata;
    logic       rd;
    logic [8:0] rdata;
    logic       empty;

    // parser side, watches empty to know the frame has drained
    modport writer (
        output wr,
        output wdata,
        input  empty
    );

    modport buffer (
        input  wr,
        input  wdata,
        input  rd,
        output rdata,
        output empty
    );

    // rdata valid the cycle after rd
    modport reader (
        output rd,
        input  rdata
    );
endinterface

////////////////////
// lookup bus
////////////////////

interface lookup_if
    import tsn_map_pkg::*;
();
    logic           req;
    logic [47:0]    key;
    logic           tsn_flag;
    logic           finish;
    lookup_result_t result;

    modport requester (
        output req,
        output key,
        output tsn_flag,
        input  finish
    );

    // finish two cycles after req
    modport responder (
        input  req,
        input  key,
        output finish,
        output result
    );

    modport receiver (
        input finish,
        input result,
        input tsn_flag
    );
endinterface

`default_nettype wire

// ==== source/tsn_map_pkg.sv ====
// shared state encodings and the lookup result type, imported by the design blocks
`default_nettype none

package tsn_map_pkg;

    ////////////////////
    // lookup result
    ////////////////////

    // field order follows the table entry layout {hit, replication, tag}
    typedef struct packed {
        logic        hit;
        logic        replication;
        logic [47:0] tsntag;
    } lookup_result_t;

    ////////////////////
    // state machines
    ////////////////////

    typedef enum logic [1:0] {
        OS_IDLE      = 2'd0,
        OS_FIRST     = 2'd1,
        OS_NOT_FIRST = 2'd2
    } outport_state_e;

    // header covers bytes up to the end of the EtherType
    typedef enum logic [2:0] {
        PS_IDLE       = 3'd0,
        PS_HEADER     = 3'd1,
        PS_BODY       = 3'd2,
        PS_LOOKUP     = 3'd3,
        PS_DRAIN_WAIT = 3'd4
    } parser_state_e;

endpackage

`default_nettype wire

// ==== source/tsn_map_defs.svh ====
// sizing and header-layout macros for the TSN mapping stage, include where a block needs them
`ifndef TSN_MAP_DEFS_SVH
`define TSN_MAP_DEFS_SVH

`default_nettype none

// buffer words, one maximum-length frame
`define TSN_MAP_FIFO_DEPTH 64

// flow table size
`define TSN_MAP_TABLE_ENTRIES 8

// 802.1CB redundancy tag marks a TSN frame
`define TSN_MAP_TSN_ETHERTYPE 16'hF1C1

// destination MAC forms the lookup key
`define TSN_MAP_KEY_BYTES 6
`define TSN_MAP_ETYPE_OFFSET 12

`default_nettype wire

`endif
